/* WritebackCore.f */
hdl/WritebackTypes.sv
hdl/MemoryRegisterWriteStage.sv
hdl/IntegerRegisterWriteStage.sv
hdl/RegisterWriteArbiter.sv
hdl/RegisterFile.sv
hdl/ActiveListStatus.sv
hdl/WritebackCore.sv
verification/WritebackChecker.sv
verification/WritebackCoreTb.sv

/* Makefile */
TOP = WritebackCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f WritebackCore.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* verification/WritebackCoreTb.sv */
/*
 * Testbench top for the writeback backend.
 * Clock, reset, seeded stimulus for six tests, DUT and checker, timeout.
 */
`timescale 1ns/10ps

module WritebackCoreTb;
    import WritebackTypes::*;

    // Six tests of under 60 cycles each, plus reset, with margin
    localparam int CycleLimit = 600;
    localparam logic [31:0] Seed = 32'hc2d62c84;

    logic ctrl;
    logic rstN;
    WbOp memOp;
    WbOp intOp;
    RecoveryRange recovery;
    logic stall;
    logic clear;
    logic sweeping;
    logic [PhyRegNumWidth-1:0] regReadNum;
    logic [ActiveListPtrWidth-1:0] alReadPtr;
    logic [DataWidth-1:0] regReadData;
    ExecutionState alReadState;
    logic intBusy;
    int passedTests;
    int failedTests;
    int cycleCount;
    logic [ActiveListPtrWidth-1:0] p;
    logic [PhyRegNumWidth-1:0] r;

    WritebackCore uut (
        .ctrl(ctrl), .rstN(rstN), .memOp(memOp), .intOp(intOp), .recovery(recovery),
        .stall(stall), .clear(clear), .regReadNum(regReadNum), .alReadPtr(alReadPtr),
        .regReadData(regReadData), .alReadState(alReadState), .intBusy(intBusy)
    );

    WritebackChecker scoreboard (
        .ctrl(ctrl), .rstN(rstN), .memOp(memOp), .intOp(intOp), .recovery(recovery),
        .stall(stall), .clear(clear), .sweeping(sweeping), .regReadNum(regReadNum),
        .alReadPtr(alReadPtr), .regReadData(regReadData), .alReadState(alReadState),
        .intBusy(intBusy), .passedTests(passedTests), .failedTests(failedTests)
    );

    always #50 ctrl = ~ctrl;

    function automatic WbOp makeOp(input logic [ActiveListPtrWidth-1:0] ptr, input logic isStore,
                                   input logic writeReg, input logic [PhyRegNumWidth-1:0] num);
        WbOp op;
        op.valid = 1'b1;
        op.activeListPtr = ptr;
        op.isStore = isStore;
        op.writeReg = writeReg;
        op.phyDstRegNum = num;
        op.data = $urandom;
        op.execState = ExecutionState'(2'(1 + ($urandom % 3)));
        return op;
    endfunction

    function automatic RecoveryRange flushRange(input logic [ActiveListPtrWidth-1:0] head,
                                                input logic [ActiveListPtrWidth-1:0] tail,
                                                input logic all);
        RecoveryRange rec;
        rec.toRecoveryPhase = 1'b1;
        rec.flushHeadPtr = head;
        rec.flushTailPtr = tail;
        rec.flushAll = all;
        return rec;
    endfunction

    // One cycle of inputs, applied just after the rising edge
    task automatic driveCycle(input WbOp m, input WbOp i, input RecoveryRange rec,
                              input logic s, input logic c);
        @(posedge ctrl);
        #5;
        memOp = m;
        intOp = i;
        recovery = rec;
        stall = s;
        clear = c;
    endtask

    task automatic driveOps(input WbOp m, input WbOp i);
        driveCycle(m, i, '0, 1'b0, 1'b0);
    endtask

    task automatic pickBases();
        p = 4'($urandom);
        r = 5'($urandom);
    endtask

    // Idle inputs until no integer op is held, then let the last write land
    task automatic drainPipes();
        driveOps('0, '0);
        @(negedge ctrl);
        while (intBusy) begin
            @(negedge ctrl);
        end
        driveOps('0, '0);
    endtask

    task automatic sweepAndReport();
        for (int i = 0; i < 2**PhyRegNumWidth; i++) begin
            @(posedge ctrl);
            #5;
            sweeping = 1'b1;
            regReadNum = i[PhyRegNumWidth-1:0];
            alReadPtr = i[ActiveListPtrWidth-1:0];
        end
        @(posedge ctrl);
        #5;
        sweeping = 1'b0;
        scoreboard.endTest();
    endtask

    task automatic finishTest();
        drainPipes();
        sweepAndReport();
    endtask

    initial begin
        void'($urandom(Seed));
        ctrl = 1'b0;
        rstN = 1'b0;
        memOp = '0;
        intOp = '0;
        recovery = '0;
        stall = 1'b0;
        clear = 1'b0;
        sweeping = 1'b0;
        regReadNum = '0;
        alReadPtr = '0;
        repeat (10) @(posedge ctrl);
        #5;
        rstN = 1'b1;

        scoreboard.beginTest("memResults");
        pickBases();
        driveOps(makeOp(p, 1'b0, 1'b1, r), '0);
        driveOps(makeOp(p + 4'd1, 1'b0, 1'b1, r + 5'd1), '0);
        driveOps(makeOp(p + 4'd2, 1'b1, 1'b1, r + 5'd2), '0);
        finishTest();

        scoreboard.beginTest("intResults");
        pickBases();
        driveOps('0, makeOp(p, 1'b0, 1'b1, r));
        // A store beside it takes no register port
        driveOps(makeOp(p + 4'd3, 1'b1, 1'b1, r + 5'd3), makeOp(p + 4'd1, 1'b0, 1'b1, r + 5'd1));
        driveOps('0, makeOp(p + 4'd2, 1'b0, 1'b0, r + 5'd2));
        finishTest();

        scoreboard.beginTest("contention");
        pickBases();
        driveOps(makeOp(p, 1'b0, 1'b1, r), makeOp(p + 4'd1, 1'b0, 1'b1, r + 5'd1));
        // Integer op is refused here, so its input stays idle
        driveOps(makeOp(p + 4'd2, 1'b0, 1'b1, r + 5'd2), '0);
        finishTest();

        scoreboard.beginTest("selectiveFlush");
        pickBases();
        driveOps(makeOp(4'd5, 1'b0, 1'b1, r), makeOp(4'd6, 1'b0, 1'b1, r + 5'd1));
        driveCycle('0, '0, flushRange(4'd5, 4'd6, 1'b0), 1'b0, 1'b0);
        // Window from 14 up to 1 wraps past the last entry
        driveOps(makeOp(4'd15, 1'b0, 1'b1, r + 5'd2), makeOp(4'd1, 1'b0, 1'b1, r + 5'd3));
        driveCycle(makeOp(4'd0, 1'b0, 1'b1, r + 5'd4), makeOp(4'd13, 1'b0, 1'b1, r + 5'd5),
                   flushRange(4'd14, 4'd1, 1'b0), 1'b0, 1'b0);
        driveCycle('0, '0, flushRange(4'd14, 4'd1, 1'b0), 1'b0, 1'b0);
        // Held integer op falls inside the window
        driveOps(makeOp(4'd8, 1'b0, 1'b1, r + 5'd6), makeOp(4'd9, 1'b0, 1'b1, r + 5'd7));
        driveOps(makeOp(4'd10, 1'b0, 1'b1, r + 5'd8), '0);
        driveCycle('0, '0, flushRange(4'd9, 4'd10, 1'b0), 1'b0, 1'b0);
        finishTest();

        scoreboard.beginTest("flushAll");
        pickBases();
        driveOps(makeOp(p, 1'b0, 1'b1, r), makeOp(p + 4'd1, 1'b0, 1'b1, r + 5'd1));
        driveCycle('0, '0, flushRange(p, p, 1'b1), 1'b0, 1'b0);
        finishTest();

        scoreboard.beginTest("stallClear");
        pickBases();
        driveOps(makeOp(p, 1'b0, 1'b1, r), makeOp(p + 4'd1, 1'b0, 1'b1, r + 5'd1));
        repeat (3) driveCycle('0, '0, '0, 1'b1, 1'b0);
        drainPipes();
        driveOps(makeOp(p + 4'd2, 1'b0, 1'b1, r + 5'd2), makeOp(p + 4'd3, 1'b0, 1'b1, r + 5'd3));
        driveCycle('0, '0, '0, 1'b0, 1'b1);
        finishTest();

        $display("Tests passed: %0d, failed: %0d", passedTests, failedTests);
        if (failedTests == 0 && passedTests == 6) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge ctrl);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* verification/WritebackChecker.sv */
/*
 * Testbench checker for the writeback backend.
 * Reference model of both stages, cycle prediction function,
 * per-cycle intBusy check, read-port sweeps and per-test reporting.
 */
`timescale 1ns/10ps

module WritebackChecker (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::WbOp memOp,
    input  WritebackTypes::WbOp intOp,
    input  WritebackTypes::RecoveryRange recovery,
    input  logic stall,
    input  logic clear,
    input  logic sweeping,
    input  logic [WritebackTypes::PhyRegNumWidth-1:0] regReadNum,
    input  logic [WritebackTypes::ActiveListPtrWidth-1:0] alReadPtr,
    input  logic [WritebackTypes::DataWidth-1:0] regReadData,
    input  WritebackTypes::ExecutionState alReadState,
    input  logic intBusy,
    output int passedTests,
    output int failedTests
);
    import WritebackTypes::*;

    typedef struct packed {
        logic memDone;
        logic memWritesReg;
        logic intDone;
        logic intWritesReg;
        logic intHeld;
    } CycleOutcome;

    logic [DataWidth-1:0] modelRegs [2**PhyRegNumWidth];
    ExecutionState modelStates [ActiveListEntries];
    WbOp memSlot;
    WbOp intSlot;
    CycleOutcome outcome;
    string testName;
    int testErrors;
    int cycle;

    // Inside when the distance from head, modulo the list size, is below the window length
    function automatic logic inFlushWindow(RecoveryRange r, logic [ActiveListPtrWidth-1:0] ptr);
        logic [ActiveListPtrWidth-1:0] offset;
        logic [ActiveListPtrWidth-1:0] span;
        offset = ptr - r.flushHeadPtr;
        span = r.flushTailPtr - r.flushHeadPtr;
        return r.toRecoveryPhase && (r.flushAll || offset < span);
    endfunction

    // What each stage does this cycle, given the ops it holds and the global controls
    function automatic CycleOutcome predictCycle(WbOp memHeld, WbOp intHeld,
                                                 RecoveryRange r, logic stallNow, logic clearNow);
        CycleOutcome o;
        logic memAlive;
        logic intAlive;
        logic intNeedsPort;
        memAlive = memHeld.valid && !clearNow && !inFlushWindow(r, memHeld.activeListPtr);
        o.memDone = memAlive && !stallNow;
        o.memWritesReg = o.memDone && memHeld.writeReg && !memHeld.isStore;
        intAlive = intHeld.valid && !clearNow && !inFlushWindow(r, intHeld.activeListPtr);
        intNeedsPort = intHeld.writeReg && !intHeld.isStore;
        // Memory owns the port whenever it writes a register
        o.intHeld = intAlive && intNeedsPort && o.memWritesReg;
        o.intDone = intAlive && !stallNow && !o.intHeld;
        o.intWritesReg = o.intDone && intNeedsPort;
        return o;
    endfunction

    initial begin
        passedTests = 0;
        failedTests = 0;
        testName = "reset";
        testErrors = 0;
    end

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            $display("PASS %s", testName);
            passedTests++;
        end else begin
            $display("FAIL %s with %0d errors", testName, testErrors);
            failedTests++;
        end
    endtask

    always @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**PhyRegNumWidth; i++) begin
                modelRegs[i] = '0;
            end
            for (int i = 0; i < ActiveListEntries; i++) begin
                modelStates[i] = ExecNotFinished;
            end
            memSlot = '0;
            intSlot = '0;
            cycle = 0;
        end else begin
            cycle++;
            outcome = predictCycle(memSlot, intSlot, recovery, stall, clear);
            if (intBusy !== outcome.intHeld) begin
                $display("Failure in %s: intBusy is %b in cycle %0d but the model expects %b",
                         testName, intBusy, cycle, outcome.intHeld);
                testErrors++;
            end
            if (sweeping) begin
                if (regReadData !== modelRegs[regReadNum]) begin
                    $display("Mismatch in %s: reg %0d expected %h actual %h",
                             testName, regReadNum, modelRegs[regReadNum], regReadData);
                    testErrors++;
                end
                if (alReadState !== modelStates[alReadPtr]) begin
                    $display("Mismatch in %s: entry %0d expected %s actual %s",
                             testName, alReadPtr, modelStates[alReadPtr].name(),
                             alReadState.name());
                    testErrors++;
                end
            end
            // Integer side first so memory wins a shared entry
            if (outcome.intDone) begin
                modelStates[intSlot.activeListPtr] = intSlot.execState;
            end
            if (outcome.intWritesReg) begin
                modelRegs[intSlot.phyDstRegNum] = intSlot.data;
            end
            if (outcome.memDone) begin
                modelStates[memSlot.activeListPtr] = memSlot.execState;
            end
            if (outcome.memWritesReg) begin
                modelRegs[memSlot.phyDstRegNum] = memSlot.data;
            end
            if (!stall) begin
                memSlot = memOp;
            end
            if (!stall && !outcome.intHeld) begin
                intSlot = intOp;
            end
        end
    end

endmodule

/* hdl/WritebackCore.sv */
/*
 * Writeback backend top: memory and integer stages,
 * register port arbiter, register file and status table.
 */
`timescale 1ns/10ps

module WritebackCore (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::WbOp memOp,
    input  WritebackTypes::WbOp intOp,
    input  WritebackTypes::RecoveryRange recovery,
    input  logic stall,
    input  logic clear,
    input  logic [WritebackTypes::PhyRegNumWidth-1:0] regReadNum,
    input  logic [WritebackTypes::ActiveListPtrWidth-1:0] alReadPtr,
    output logic [WritebackTypes::DataWidth-1:0] regReadData,
    output WritebackTypes::ExecutionState alReadState,
    output logic intBusy
);
    import WritebackTypes::*;

    AlWrite memAlWrite;
    AlWrite intAlWrite;
    RegWrite memRegReq;
    RegWrite intRegReq;
    RegWrite regWrite;
    logic intGrant;

    MemoryRegisterWriteStage memStage (
        .ctrl(ctrl), .rstN(rstN), .op(memOp), .recovery(recovery),
        .stall(stall), .clear(clear), .alWrite(memAlWrite), .regReq(memRegReq)
    );

    IntegerRegisterWriteStage intStage (
        .ctrl(ctrl), .rstN(rstN), .op(intOp), .recovery(recovery),
        .stall(stall), .clear(clear), .grant(intGrant),
        .alWrite(intAlWrite), .regReq(intRegReq), .busy(intBusy)
    );

    RegisterWriteArbiter arbiter (
        .memReq(memRegReq), .intReq(intRegReq), .regWrite(regWrite), .intGrant(intGrant)
    );

    RegisterFile regFile (
        .ctrl(ctrl), .rstN(rstN), .write(regWrite),
        .readNum(regReadNum), .readData(regReadData)
    );

    ActiveListStatus alStatus (
        .ctrl(ctrl), .rstN(rstN), .memWrite(memAlWrite), .intWrite(intAlWrite),
        .readPtr(alReadPtr), .readState(alReadState)
    );

endmodule

/* hdl/ActiveListStatus.sv */
/*
 * Execution-state table of the active list.
 * Two write ports, one per writeback stage, one read port.
 */
`timescale 1ns/10ps

module ActiveListStatus (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::AlWrite memWrite,
    input  WritebackTypes::AlWrite intWrite,
    input  logic [WritebackTypes::ActiveListPtrWidth-1:0] readPtr,
    output WritebackTypes::ExecutionState readState
);
    import WritebackTypes::*;

    ExecutionState states [ActiveListEntries];

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < ActiveListEntries; i++) begin
                states[i] <= ExecNotFinished;
            end
        end else begin
            if (intWrite.we) begin
                states[intWrite.ptr] <= intWrite.state;
            end
            // Later assignment, so memory wins on a shared pointer
            if (memWrite.we) begin
                states[memWrite.ptr] <= memWrite.state;
            end
        end
    end

    assign readState = states[readPtr];

endmodule

/* hdl/RegisterFile.sv */
/*
 * Physical register file, one write port and one
 * combinational read port.
 */
`timescale 1ns/10ps

module RegisterFile (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::RegWrite write,
    input  logic [WritebackTypes::PhyRegNumWidth-1:0] readNum,
    output logic [WritebackTypes::DataWidth-1:0] readData
);
    import WritebackTypes::*;

    localparam int NumRegs = 1 << PhyRegNumWidth;

    logic [DataWidth-1:0] regs [NumRegs];

    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (write.we) begin
            regs[write.num] <= write.data;
        end
    end

    assign readData = regs[readNum];

endmodule

/* hdl/RegisterWriteArbiter.sv */
/*
 * Fixed-priority selection for the single register file write port.
 * Memory results always win.
 */
`timescale 1ns/10ps

module RegisterWriteArbiter (
    input  WritebackTypes::RegWrite memReq,
    input  WritebackTypes::RegWrite intReq,
    output WritebackTypes::RegWrite regWrite,
    output logic intGrant
);
    import WritebackTypes::*;

    always_comb begin
        // Integer side gets any cycle the memory side leaves free
        intGrant = !memReq.we;
        if (memReq.we) begin
            regWrite = memReq;
        end else begin
            regWrite = intReq;
        end
    end

endmodule

/* hdl/IntegerRegisterWriteStage.sv */
/*
 * Writeback stage for integer results.
 * Holds an op that lost the register port and reports busy.
 */
`timescale 1ns/10ps

module IntegerRegisterWriteStage (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::WbOp op,
    input  WritebackTypes::RecoveryRange recovery,
    input  logic stall,
    input  logic clear,
    input  logic grant,
    output WritebackTypes::AlWrite alWrite,
    output WritebackTypes::RegWrite regReq,
    output logic busy
);
    import WritebackTypes::*;

    WbOp pipeReg;
    logic live;
    logic needPort;
    logic update;
    logic hold;

    always_comb begin
        // Op survives this cycle unless cleared or flushed
        live = pipeReg.valid && !clear && !SelectiveFlush(recovery, pipeReg.activeListPtr);
        needPort = pipeReg.writeReg && !pipeReg.isStore;
        update = live && !stall && (!needPort || grant);
        hold = live && needPort && !grant;
        busy = hold;
    end

    // A refused op stays put and is re-evaluated next cycle
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            pipeReg <= '0;
        end else if (!stall && !hold) begin
            pipeReg <= op;
        end
    end

    always_comb begin
        alWrite.we = update;
        alWrite.ptr = pipeReg.activeListPtr;
        alWrite.state = pipeReg.execState;
    end

    // Request goes out while the op is live; the arbiter decides who writes
    always_comb begin
        regReq.we = live && !stall && needPort;
        regReq.num = pipeReg.phyDstRegNum;
        regReq.data = pipeReg.data;
    end

endmodule

/* hdl/MemoryRegisterWriteStage.sv */
/*
 * Writeback stage for load and store results.
 * Pipeline register, flush filtering, active list update
 * and register file write request.
 */
`timescale 1ns/10ps

module MemoryRegisterWriteStage (
    input  logic ctrl,
    input  logic rstN,
    input  WritebackTypes::WbOp op,
    input  WritebackTypes::RecoveryRange recovery,
    input  logic stall,
    input  logic clear,
    output WritebackTypes::AlWrite alWrite,
    output WritebackTypes::RegWrite regReq
);
    import WritebackTypes::*;

    WbOp pipeReg;
    logic flush;
    logic update;

    // Pipeline register frozen under stall
    always_ff @(posedge ctrl or negedge rstN) begin
        if (!rstN) begin
            pipeReg <= '0;
        end else if (!stall) begin
            pipeReg <= op;
        end
    end

    always_comb begin
        flush = SelectiveFlush(recovery, pipeReg.activeListPtr);
        update = pipeReg.valid && !stall && !clear && !flush;
    end

    // Completion state goes to the active list on every update
    always_comb begin
        alWrite.we = update;
        alWrite.ptr = pipeReg.activeListPtr;
        alWrite.state = pipeReg.execState;
    end

    // Stores only touch the status table
    always_comb begin
        regReq.we = update && pipeReg.writeReg && !pipeReg.isStore;
        regReq.num = pipeReg.phyDstRegNum;
        regReq.data = pipeReg.data;
    end

endmodule

/* hdl/WritebackTypes.sv */
/*
 * Shared types for the completion and writeback backend:
 * sizes, execution-state encoding, result, recovery and write structs,
 * and the selective flush range test.
 */
package WritebackTypes;

    // Active list and physical register sizes
    localparam int ActiveListPtrWidth = 4;
    localparam int ActiveListEntries = 16;
    localparam int PhyRegNumWidth = 5;
    localparam int DataWidth = 32;

    typedef enum logic [1:0] {
        ExecNotFinished,
        ExecSuccess,
        ExecRefetch,
        ExecFault
    } ExecutionState;

    // One result entering a writeback stage
    typedef struct packed {
        logic valid;
        logic [ActiveListPtrWidth-1:0] activeListPtr;
        logic isStore;
        logic writeReg;
        logic [PhyRegNumWidth-1:0] phyDstRegNum;
        logic [DataWidth-1:0] data;
        ExecutionState execState;
    } WbOp;

    // Flush window from the recovery logic, head inclusive and tail exclusive
    typedef struct packed {
        logic toRecoveryPhase;
        logic [ActiveListPtrWidth-1:0] flushHeadPtr;
        logic [ActiveListPtrWidth-1:0] flushTailPtr;
        logic flushAll;
    } RecoveryRange;

    typedef struct packed {
        logic we;
        logic [PhyRegNumWidth-1:0] num;
        logic [DataWidth-1:0] data;
    } RegWrite;

    typedef struct packed {
        logic we;
        logic [ActiveListPtrWidth-1:0] ptr;
        ExecutionState state;
    } AlWrite;

    // True when ptr falls in the circular flush window or flush-all is set
    function automatic logic SelectiveFlush(
        RecoveryRange range,
        logic [ActiveListPtrWidth-1:0] ptr
    );
        logic inRange;
        if (range.flushHeadPtr <= range.flushTailPtr) begin
            // Not wrapped, equal pointers give an empty window
            inRange = (ptr >= range.flushHeadPtr) && (ptr < range.flushTailPtr);
        end else begin
            inRange = (ptr >= range.flushHeadPtr) || (ptr < range.flushTailPtr);
        end
        return range.toRecoveryPhase && (range.flushAll || inRange);
    endfunction

endpackage
